/* pi_bus_ctrl.sv */
// pi_bus_ctrl: bus controller FSM for grant, slave select, transfer end and timeout
module pi_bus_ctrl
(
   input  logic                clk,
   input  logic                rst,
   input  logic                bus_req,
   input  pi_bus_pkg::pi_bus_t bus,
   input  pi_bus_pkg::pi_ack_e ack,
   input  logic                expired,
   output logic                gnt,
   output logic                sel,
   output logic                xfer_done,
   output logic                tout,
   output logic                run,
   output logic                clear
);

   typedef enum logic [2:0]
   {
      ST_IDLE,
      ST_REQ,
      ST_ADDR,
      ST_ADDRDATA,                            // bus held under lock
      ST_DATA
   } state_e;

   state_e state;
   state_e state_nxt;
   logic   xfer_on;
   logic   hit;

   assign xfer_on = bus.opc != pi_bus_pkg::OPC_NOP;
   assign hit     = bus.a.f.region == pi_bus_pkg::pi_slave_region;

   assign gnt       = state == ST_REQ;
   assign sel       = (state == ST_DATA) && xfer_on && hit;
   assign xfer_done = (state == ST_DATA) && (expired || ack != pi_bus_pkg::ACK_WAT);
   assign tout      = (state == ST_DATA) && expired;
   assign run       = state == ST_DATA;     // every data cycle is counted
   assign clear     = xfer_done;

   always_comb
   begin
      state_nxt = state;
      case (state)
         ST_IDLE:
         begin
            if (bus_req)
               state_nxt = ST_REQ;
         end
         ST_REQ:
            state_nxt = ST_ADDR;              // one grant cycle
         ST_ADDR:
         begin
            if (xfer_on)
               state_nxt = ST_DATA;
            else
               state_nxt = ST_IDLE;           // master dropped the transfer
         end
         ST_ADDRDATA:
         begin
            if (xfer_on)
               state_nxt = ST_DATA;           // locked follow-on, no grant needed
            else if (!bus.lock)
               state_nxt = bus_req ? ST_REQ : ST_IDLE;
         end
         ST_DATA:
         begin
            if (xfer_done)
            begin
               // a timed-out transfer always gives the bus up
               if (bus.lock && !expired)
                  state_nxt = ST_ADDRDATA;
               else if (bus_req)
                  state_nxt = ST_REQ;
               else
                  state_nxt = ST_IDLE;
            end
         end
         default:
            state_nxt = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         state <= ST_IDLE;
      else
         state <= state_nxt;
   end

   a_gnt_sel: assert property (@(posedge clk) disable iff (rst) !(gnt && sel));

   a_tout_done: assert property (@(posedge clk) disable iff (rst) tout |-> xfer_done);

endmodule

/* pi_bus_pkg.sv */
// bus widths, timeout limit, acknowledge and opcode codes, address union, request/response/bus structs
package pi_bus_pkg;

   localparam int pi_addr_w    = 30;          // word address on the bus
   localparam int pi_data_w    = 32;
   localparam int pi_tout_w    = 8;           // timer count width
   localparam int pi_mem_depth = 16;          // slave register words

   // wait-phase cycles before a transfer is aborted
   localparam logic [pi_tout_w-1:0] pi_tout_limit = 8'd255;

   localparam logic [1:0] pi_slave_region = 2'b11;

   // slave acknowledge, none means nobody answers the address
   typedef enum logic [2:0]
   {
      ACK_NONE = 3'b000,
      ACK_RDY  = 3'b001,
      ACK_WAT  = 3'b010,
      ACK_ERR  = 3'b011
   } pi_ack_e;

   typedef enum logic [3:0]
   {
      OPC_NOP  = 4'h0,                        // no transfer
      OPC_WORD = 4'h2                         // single word transfer
   } pi_opc_e;

   typedef struct packed
   {
      logic [1:0]  region;                    // decoded by the controller
      logic [23:0] unused;
      logic [3:0]  index;                     // register index in the slave
   } pi_addr_f_t;

   typedef union packed
   {
      logic [pi_addr_w-1:0] word;
      pi_addr_f_t           f;
   } pi_addr_u;

   typedef struct packed
   {
      pi_addr_u             addr;
      logic                 read;
      logic [pi_data_w-1:0] wdata;
      logic                 lock;             // keep the bus for the next request
   } pi_req_t;

   typedef struct packed
   {
      logic [pi_data_w-1:0] rdata;
      logic                 err;
      logic                 tout;
   } pi_rsp_t;

   // signals driven by the master onto the bus
   typedef struct packed
   {
      pi_addr_u             a;
      pi_opc_e              opc;
      logic                 read;
      logic                 lock;
      logic [pi_data_w-1:0] wdata;
   } pi_bus_t;

endpackage

/* pi_bus_top.sv */
// pi_bus_top: master port, bus controller, timeout timer and slave memory
module pi_bus_top
(
   input  logic                clk,
   input  logic                rst,
   input  logic                req_valid,
   input  pi_bus_pkg::pi_req_t req,
   input  logic                rsp_ready,
   input  logic                peripheral_ready,
   output logic                req_ready,
   output logic                rsp_valid,
   output pi_bus_pkg::pi_rsp_t rsp
);

   pi_bus_pkg::pi_bus_t              bus;
   pi_bus_pkg::pi_ack_e              ack;
   logic [pi_bus_pkg::pi_data_w-1:0] rdata;
   logic                             bus_req;
   logic                             gnt;
   logic                             sel;
   logic                             xfer_done;
   logic                             tout;
   logic                             run;
   logic                             clear;
   logic                             expired;

   pi_master_port u_master (.clk, .rst, .req_valid, .req, .rsp_ready, .gnt, .xfer_done,
                            .tout, .ack, .rdata, .req_ready, .rsp_valid, .rsp, .bus_req,
                            .bus);

   pi_bus_ctrl u_ctrl (.clk, .rst, .bus_req, .bus, .ack, .expired, .gnt, .sel, .xfer_done,
                       .tout, .run, .clear);

   pi_tout_timer u_timer (.clk, .rst, .run, .clear, .expired);

   pi_slave_mem u_slave (.clk, .rst, .sel, .bus, .peripheral_ready, .ack, .rdata);

endmodule

/* pi_master_port.sv */
// pi_master_port: request/response handshake and bus master signalling
module pi_master_port
(
   input  logic                                 clk,
   input  logic                                 rst,
   input  logic                                 req_valid,
   input  pi_bus_pkg::pi_req_t                  req,
   input  logic                                 rsp_ready,
   input  logic                                 gnt,
   input  logic                                 xfer_done,
   input  logic                                 tout,
   input  pi_bus_pkg::pi_ack_e                  ack,
   input  logic [pi_bus_pkg::pi_data_w-1:0]     rdata,
   output logic                                 req_ready,
   output logic                                 rsp_valid,
   output pi_bus_pkg::pi_rsp_t                  rsp,
   output logic                                 bus_req,
   output pi_bus_pkg::pi_bus_t                  bus
);

   pi_bus_pkg::pi_req_t req_q;
   logic live;                                // high from the first cycle after reset
   logic pend;                                // request held, transfer not finished
   logic addr_on;                             // address and opcode on the bus
   logic owned;                               // grant kept by a locked transfer
   logic accept;
   logic finish;

   assign req_ready = live && !pend && !rsp_valid;
   assign accept    = req_valid && req_ready;
   assign finish    = xfer_done && addr_on;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         live      <= 1'b0;
         pend      <= 1'b0;
         bus_req   <= 1'b0;
         addr_on   <= 1'b0;
         owned     <= 1'b0;
         rsp_valid <= 1'b0;
      end
      else
      begin
         live <= 1'b1;
         if (accept)
         begin
            pend <= 1'b1;
            if (owned)
               addr_on <= 1'b1;               // bus already held, skip request
            else
               bus_req <= 1'b1;
         end
         if (gnt && bus_req)
         begin
            bus_req <= 1'b0;
            addr_on <= 1'b1;
         end
         if (finish)
         begin
            pend      <= 1'b0;
            addr_on   <= 1'b0;
            owned     <= req_q.lock && !tout;
            rsp_valid <= 1'b1;
         end
         else if (rsp_valid && rsp_ready)
            rsp_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept)
         req_q <= req;
      if (finish)
      begin
         rsp.rdata <= rdata;
         rsp.err   <= (ack == pi_bus_pkg::ACK_ERR) || (ack == pi_bus_pkg::ACK_NONE);
         rsp.tout  <= tout;
      end
   end

   always_comb
   begin
      bus      = '0;
      bus.lock = owned;                       // keeps the grant between transfers
      if (addr_on)
      begin
         bus.a.word = req_q.addr.word;
         bus.opc    = pi_bus_pkg::OPC_WORD;
         bus.read   = req_q.read;
         bus.lock   = req_q.lock;
         bus.wdata  = req_q.wdata;
      end
   end

   a_rsp_hold: assert property (@(posedge clk) disable iff (rst)
      rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));

endmodule

/* pi_slave_mem.sv */
// pi_slave_mem: 16-word slave register memory with wait-state acknowledge
module pi_slave_mem
(
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             sel,
   input  pi_bus_pkg::pi_bus_t              bus,
   input  logic                             peripheral_ready,
   output pi_bus_pkg::pi_ack_e              ack,
   output logic [pi_bus_pkg::pi_data_w-1:0] rdata
);

   logic [pi_bus_pkg::pi_data_w-1:0] mem [pi_bus_pkg::pi_mem_depth];
   logic                             wr_en;

   // slow device behind the registers stretches the data phase
   always_comb
   begin
      if (!sel)
         ack = pi_bus_pkg::ACK_NONE;
      else if (!peripheral_ready)
         ack = pi_bus_pkg::ACK_WAT;
      else
         ack = pi_bus_pkg::ACK_RDY;
   end

   assign wr_en = sel && peripheral_ready && !bus.read;  // write on ready only

   always_ff @(posedge clk)
   begin
      if (wr_en)
         mem[bus.a.f.index] <= bus.wdata;
   end

   assign rdata = mem[bus.a.f.index];

   // unmapped regions must never see an answer
   a_unmapped: assert property (@(posedge clk) disable iff (rst)
      bus.a.f.region != pi_bus_pkg::pi_slave_region |-> ack == pi_bus_pkg::ACK_NONE);

   a_wr_opc: assert property (@(posedge clk) disable iff (rst)
      wr_en |-> bus.opc != pi_bus_pkg::OPC_NOP);

endmodule

/* pi_tout_timer.sv */
// pi_tout_timer: wait-phase counter that flags transfer timeout
module pi_tout_timer
(
   input  logic clk,
   input  logic rst,
   input  logic run,
   input  logic clear,
   output logic expired
);

   logic [pi_bus_pkg::pi_tout_w-1:0] cnt;
   logic [pi_bus_pkg::pi_tout_w-1:0] cnt_nxt;

   assign cnt_nxt = cnt + 1'b1;

   always_ff @(posedge clk)
   begin
      if (rst || clear)                       // clear wins over run
      begin
         cnt     <= '0;
         expired <= 1'b0;
      end
      else if (run)
      begin
         if (cnt_nxt == pi_bus_pkg::pi_tout_limit)
         begin
            cnt     <= '0;                    // wrap at the limit
            expired <= 1'b1;
         end
         else
         begin
            cnt     <= cnt_nxt;
            expired <= 1'b0;
         end
      end
      else
         expired <= 1'b0;
   end

   a_exp_run: assert property (@(posedge clk) disable iff (rst) expired |-> run);

endmodule

/* project.f */
pi_bus_pkg.sv
pi_tout_timer.sv
pi_bus_ctrl.sv
pi_master_port.sv
pi_slave_mem.sv
pi_bus_top.sv
tb_pi_bus.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert -f project.f --top-module tb_pi_bus -o sim_pi_bus \
   || { echo "build failed"; exit 1; }
out=$(./obj_dir/sim_pi_bus)
echo "$out"
echo "$out" | grep -q "TEST PASSED" && echo "simulation ok" || { echo "simulation failed"; exit 1; }

/* tb_pi_bus.sv */
// testbench for the PI-bus subsystem: clock, reset, LFSR stimulus, assertions, cycle limit, summary
module tb_pi_bus;
   timeunit 1ns;
   timeprecision 100ps;

   typedef enum logic [1:0] {PR_HIGH, PR_LOW, PR_RAND} pr_mode_e;

   localparam int         cycle_limit = 4000;  // all tests plus two full timeouts, with margin
   localparam logic [1:0] slv         = pi_bus_pkg::pi_slave_region;

   logic                             clk;
   logic                             rst;
   logic                             req_valid;
   logic                             req_ready;
   pi_bus_pkg::pi_req_t              req;
   logic                             rsp_valid;
   logic                             rsp_ready;
   pi_bus_pkg::pi_rsp_t              rsp;
   logic                             peripheral_ready;
   logic [15:0]                      lfsr;
   logic [pi_bus_pkg::pi_data_w-1:0] ref_mem [16];   // model of the slave registers
   pr_mode_e                         pr_mode;
   logic                             bp_on;          // random rsp_ready
   string                            test_name;
   logic [pi_bus_pkg::pi_data_w-1:0] exp_rdata;
   logic                             exp_err;
   logic                             exp_tout;
   logic                             exp_chk_data;
   int                               exp_min_lat;
   int                               exp_max_lat;
   int                               lat;            // cycles from accept to rsp_valid
   int                               req_count;
   int                               rsp_count;
   int                               cycle_count;
   int                               mismatches;
   int                               failures;

   pi_bus_top DUT (.clk, .rst, .req_valid, .req, .rsp_ready, .peripheral_ready, .req_ready,
                   .rsp_valid, .rsp);

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic rand_bits(input int n, output logic [31:0] v);
      int i;
      v = '0;
      for (i = 0; i < n; i++)
      begin
         lfsr = lfsr_next(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
   endtask

   task automatic value_mismatch(input string what, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
      mismatches++;
      $display("MISMATCH %s %s expected %h actual %h", test_name, what, exp_v, act_v);
   endtask

   task automatic latency_mismatch(input int act_v);
      mismatches++;
      $display("MISMATCH %s latency expected %0d to %0d actual %0d", test_name,
               exp_min_lat, exp_max_lat, act_v);
   endtask

   task automatic protocol_error(input string msg);
      failures++;
      $display("ERROR in %s: %s", test_name, msg);
   endtask

   // one clock, then drive the per-cycle inputs
   task automatic next_cycle();
      logic [31:0] b;
      @(posedge clk);
      #1;
      case (pr_mode)
         PR_HIGH: peripheral_ready = 1'b1;
         PR_LOW:  peripheral_ready = 1'b0;
         default:
         begin
            rand_bits(1, b);
            peripheral_ready = b[0];
         end
      endcase
      if (bp_on)
      begin
         rand_bits(1, b);
         rsp_ready = b[0];
      end
      else
         rsp_ready = 1'b1;
   endtask

   // one request through the whole handshake, expectations taken from the bus rules
   task automatic run_xfer(input logic [1:0] region, input logic [3:0] idx, input logic rd,
                           input logic [31:0] wd, input logic lk, input logic followon);
      logic [31:0] u;
      logic        hit;
      int          limit;
      rand_bits(24, u);
      limit = int'(pi_bus_pkg::pi_tout_limit);
      hit   = region == slv;
      while (!req_ready)
         next_cycle();
      req.addr.f.region = region;
      req.addr.f.unused = u[23:0];
      req.addr.f.index  = idx;
      req.read          = rd;
      req.wdata         = wd;
      req.lock          = lk;
      req_valid         = 1'b1;
      exp_err           = !hit;
      exp_tout          = hit && (pr_mode == PR_LOW);
      exp_chk_data      = rd && hit && !exp_tout;
      exp_rdata         = ref_mem[idx];
      if (exp_tout)
      begin
         exp_min_lat = 4 + limit;                 // every data cycle is a wait cycle
         exp_max_lat = 4 + limit;
      end
      else if (followon)
      begin
         exp_min_lat = 1;
         exp_max_lat = 3;                         // grant already held
      end
      else
      begin
         exp_min_lat = 4;
         exp_max_lat = 4 + limit;
      end
      if (!rd && hit && !exp_tout)
         ref_mem[idx] = wd;
      next_cycle();                               // accepted on this edge
      req_valid = 1'b0;
      while (!(rsp_valid && rsp_ready))
         next_cycle();
      next_cycle();                               // response taken on this edge
   endtask

   always @(posedge clk)
   begin
      if (rst)
      begin
         req_count <= 0;
         rsp_count <= 0;
         lat       <= 0;
      end
      else
      begin
         if (req_valid && req_ready)
         begin
            req_count <= req_count + 1;
            lat       <= 0;
         end
         else if (!rsp_valid)
            lat <= lat + 1;
         if (rsp_valid && rsp_ready)
            rsp_count <= rsp_count + 1;
      end
   end

   always @(posedge clk)
   begin
      if (rst)
         cycle_count <= 0;
      else
         cycle_count <= cycle_count + 1;
      if (cycle_count == cycle_limit)
      begin
         $display("run stopped at the cycle limit of %0d in %s, %0d mismatches, %0d other",
                  cycle_limit, test_name, mismatches, failures);
         $display("TEST FAILED");
         $finish;
      end
   end

   a_rdata: assert property (@(posedge clk) disable iff (rst)
      rsp_valid && rsp_ready && exp_chk_data |-> rsp.rdata == exp_rdata)
      else value_mismatch("rdata", exp_rdata, rsp.rdata);

   a_err: assert property (@(posedge clk) disable iff (rst)
      rsp_valid && rsp_ready |-> rsp.err == exp_err)
      else value_mismatch("err", 32'(exp_err), 32'(rsp.err));

   a_tout: assert property (@(posedge clk) disable iff (rst)
      rsp_valid && rsp_ready |-> rsp.tout == exp_tout)
      else value_mismatch("tout", 32'(exp_tout), 32'(rsp.tout));

   a_lat: assert property (@(posedge clk) disable iff (rst)
      $rose(rsp_valid) |-> lat >= exp_min_lat && lat <= exp_max_lat)
      else latency_mismatch(lat);

   a_hold: assert property (@(posedge clk) disable iff (rst)
      rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
      else protocol_error("response changed or dropped while rsp_ready was low");

   a_ready_low: assert property (@(posedge clk) disable iff (rst)
      rsp_valid |-> !req_ready)
      else protocol_error("req_ready was high while a response was waiting");

   a_no_extra: assert property (@(posedge clk) disable iff (rst)
      rsp_valid && rsp_ready |-> rsp_count < req_count)
      else protocol_error("response taken without an outstanding request");

   initial
   begin
      logic [31:0] v;
      logic [31:0] d;
      int          i;
      lfsr             = 16'd36469;
      rst              = 1'b1;
      req_valid        = 1'b0;
      req              = '0;
      rsp_ready        = 1'b1;
      peripheral_ready = 1'b1;
      pr_mode          = PR_HIGH;
      bp_on            = 1'b0;
      test_name        = "reset";
      exp_rdata        = '0;
      exp_err          = 1'b0;
      exp_tout         = 1'b0;
      exp_chk_data     = 1'b0;
      exp_min_lat      = 0;
      exp_max_lat      = 0;
      mismatches       = 0;
      failures         = 0;
      repeat (8) @(posedge clk);
      #1 rst = 1'b0;
      next_cycle();

      test_name = "write_read";
      for (i = 0; i < 16; i++)
      begin
         rand_bits(32, d);
         run_xfer(slv, 4'(i), 1'b0, d, 1'b0, 1'b0);   // every register gets a known value
      end
      for (i = 0; i < 8; i++)
      begin
         rand_bits(4, v);
         rand_bits(32, d);
         run_xfer(slv, v[3:0], 1'b0, d, 1'b0, 1'b0);
         rand_bits(4, v);
         run_xfer(slv, v[3:0], 1'b1, 32'h0, 1'b0, 1'b0);
      end

      test_name = "wait_states";
      pr_mode   = PR_RAND;
      for (i = 0; i < 12; i++)
      begin
         rand_bits(4, v);
         rand_bits(32, d);
         run_xfer(slv, v[3:0], 1'b0, d, 1'b0, 1'b0);
         rand_bits(4, v);
         run_xfer(slv, v[3:0], 1'b1, 32'h0, 1'b0, 1'b0);
      end

      test_name = "timeout";
      pr_mode   = PR_LOW;
      next_cycle();
      rand_bits(4, v);
      rand_bits(32, d);
      run_xfer(slv, v[3:0], 1'b0, d, 1'b0, 1'b0);     // write never lands
      run_xfer(slv, v[3:0], 1'b1, 32'h0, 1'b0, 1'b0);
      pr_mode = PR_HIGH;
      next_cycle();
      run_xfer(slv, v[3:0], 1'b1, 32'h0, 1'b0, 1'b0);

      test_name = "unmapped";
      for (i = 0; i < 3; i++)
      begin
         rand_bits(4, v);
         rand_bits(32, d);
         run_xfer(2'(i), v[3:0], 1'b0, d, 1'b0, 1'b0);
         run_xfer(2'(i), v[3:0], 1'b1, 32'h0, 1'b0, 1'b0);
         run_xfer(slv, v[3:0], 1'b1, 32'h0, 1'b0, 1'b0);  // register still holds old value
      end

      test_name = "locked";
      rand_bits(4, v);
      rand_bits(32, d);
      run_xfer(slv, v[3:0], 1'b0, d, 1'b1, 1'b0);     // first one still requests the bus
      run_xfer(slv, v[3:0], 1'b1, 32'h0, 1'b1, 1'b1);
      for (i = 0; i < 3; i++)
      begin
         rand_bits(4, v);
         rand_bits(32, d);
         run_xfer(slv, v[3:0], 1'b0, d, 1'b1, 1'b1);
         run_xfer(slv, v[3:0], 1'b1, 32'h0, 1'b1, 1'b1);
      end
      run_xfer(slv, v[3:0], 1'b1, 32'h0, 1'b0, 1'b1);  // releases the bus

      test_name = "backpressure";
      bp_on     = 1'b1;
      next_cycle();
      for (i = 0; i < 10; i++)
      begin
         rand_bits(4, v);
         rand_bits(32, d);
         run_xfer(slv, v[3:0], 1'b0, d, 1'b0, 1'b0);
         rand_bits(4, v);
         run_xfer(slv, v[3:0], 1'b1, 32'h0, 1'b0, 1'b0);
      end
      bp_on = 1'b0;
      repeat (4) next_cycle();

      test_name = "summary";
      if (req_count != rsp_count)
         value_mismatch("response count", 32'(req_count), 32'(rsp_count));
      $display("errors: %0d value mismatches, %0d other failures", mismatches, failures);
      if (mismatches == 0 && failures == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule
